//--- Makefile
# Verilator build and run of the cache directory testbench

TOP := cacheDirectoryTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f tb.f --top-module $(TOP) --Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

//--- hdl/cacheDirectory.sv
`timescale 1ns/1ps

module cacheDirectory (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reqValid,
  input  cacheGeomPkg::tagT      reqTag,
  input  cacheGeomPkg::setIndexT reqSet,
  input  logic                   invalidateAll,
  output logic                   respValid,
  output logic                   respHit,
  output cacheGeomPkg::wayMaskT  respWay
);

  ////////////////////////////////////////
  // Lookup bundle between the two halves
  ////////////////////////////////////////

  // Set, way masks and LRU command of one lookup
  lookupIf lookup ();

  ////////////////////////////////////////
  // Tag and valid side
  ////////////////////////////////////////

  // Owns the response, one cycle after reqValid
  tagDirectory tagDirectory_inst (
    .clk           (clk),
    .reset         (reset),
    .reqValid      (reqValid),
    .reqTag        (reqTag),
    .reqSet        (reqSet),
    .invalidateAll (invalidateAll),
    .respValid     (respValid),
    .respHit       (respHit),
    .respWay       (respWay),
    .lookup        (lookup.directory)
  );

  ////////////////////////////////////////
  // Replacement side
  ////////////////////////////////////////

  // Tree pseudo-LRU, victim back through the bundle
  pseudoLru pseudoLru_inst (
    .clk           (clk),
    .reset         (reset),
    .invalidateAll (invalidateAll),
    .lookup        (lookup.replace)
  );

endmodule

//--- hdl/cacheGeomPkg.sv
`include "cache_macros.svh"

package cacheGeomPkg;

  ////////////////////////////////////////
  // Address split
  ////////////////////////////////////////

  // Upper part of the request address
  // One entry of the tag array
  typedef logic [`TAG_BITS-1:0] tagT;

  // Lower part of the request address
  // Selects one row in every array
  typedef logic [`SET_BITS-1:0] setIndexT;

  ////////////////////////////////////////
  // Way vectors
  ////////////////////////////////////////

  // One bit per way
  // One-hot when it names a way
  // Plain bit set when it lists valid ways
  typedef logic [`NUM_WAYS-1:0] wayMaskT;

endpackage

//--- hdl/lookupIf.sv
`timescale 1ns/1ps

interface lookupIf;

  import cacheGeomPkg::*;

  // Set addressed by the request in stage one
  setIndexT setIndex;

  // Stage two view of the set
  // Valid bits of all ways
  wayMaskT  validWay;
  // Valid tag match, zero on a miss
  wayMaskT  hitWay;

  // Stage two commands
  // Promote the accessed way
  logic     updateEn;
  // Miss, write the tag into the victim
  logic     fill;

  // Victim chosen by the replacement logic, one-hot
  wayMaskT  victimWay;

  // Tag and valid side
  modport directory (
    output setIndex,
    output validWay,
    output hitWay,
    output updateEn,
    output fill,
    input  victimWay
  );

  // Replacement side
  modport replace (
    input  setIndex,
    input  validWay,
    input  hitWay,
    input  updateEn,
    input  fill,
    output victimWay
  );

endinterface

//--- hdl/pseudoLru.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module pseudoLru (
  input  logic     clk,
  input  logic     reset,
  input  logic     invalidateAll,
  lookupIf.replace lookup
);

  import cacheGeomPkg::*;
  import replacePkg::*;

  // One tree entry per set
  treeBitsT treeMem [`NUM_SETS];

  // Stage two copy of the looked-up set
  treeBitsT curTree;
  setIndexT s2Set;

  // Promoted tree for the stage two set
  treeBitsT nextTree;

  // Victim selection
  logic     allValid;
  wayMaskT  firstInvalid;
  wayIndexT treeWay;
  wayMaskT  treeVictim;

  // Way touched by this access
  wayMaskT  accessWay;
  wayIndexT accessIdx;

  ////////////////////////////////////////
  // Stage one tree capture
  ////////////////////////////////////////

  // Tree bits of the addressed set
  // Bypassed when stage two writes that row
  always_ff @(posedge clk) begin : stageTree
    if (reset || invalidateAll) begin
      curTree <= '0;
    end else if (lookup.updateEn && (s2Set == lookup.setIndex)) begin
      curTree <= nextTree;
    end else begin
      curTree <= treeMem[lookup.setIndex];
    end
  end

  // Row written at the end of stage two
  always_ff @(posedge clk) begin : stageSet
    s2Set <= lookup.setIndex;
  end

  ////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////

  assign allValid = &lookup.validWay;

  // Lowest zero bit of the valid mask
  assign firstInvalid = ~lookup.validWay & (lookup.validWay + 1'b1);

  // Walk down from the root
  // Node k sits at bit NUM_WAYS-1-k
  always_comb begin : treeWalk
    int node;
    node = 1;
    for (int lvl = 0; lvl < `WAY_BITS; lvl++) begin
      // 0 takes the lower child, 1 the upper
      node = 2 * node + int'(curTree[`NUM_WAYS - 1 - node]);
    end
    // Leaves are numbered from NUM_WAYS upwards
    treeWay = wayIndexT'(node - `NUM_WAYS);
  end

  assign treeVictim = wayMaskT'(1) << treeWay;

  // Empty ways are used before anything is evicted
  assign lookup.victimWay = allValid ? treeVictim : firstInvalid;

  ////////////////////////////////////////
  // Promotion
  ////////////////////////////////////////

  // Victim when filling and the hit way otherwise
  assign accessWay = lookup.fill ? lookup.victimWay : lookup.hitWay;

  // One-hot to binary
  always_comb begin : encodeAccess
    accessIdx = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (accessWay[w]) begin
        accessIdx = accessIdx | wayIndexT'(w);
      end
    end
  end

  // Every node on the path points away from the accessed way
  always_comb begin : promote
    int   node;
    logic dir;
    node     = 1;
    nextTree = curTree;
    for (int lvl = 0; lvl < `WAY_BITS; lvl++) begin
      // Way number bits taken MSB first
      // Root decides the top half
      dir                             = accessIdx[`WAY_BITS - 1 - lvl];
      nextTree[`NUM_WAYS - 1 - node]  = ~dir;
      node                            = 2 * node + int'(dir);
    end
  end

  // Tree write at the end of stage two
  // Invalidate clears every set
  always_ff @(posedge clk) begin : treeArray
    if (reset || invalidateAll) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        treeMem[s] <= '0;
      end
    end else if (lookup.updateEn) begin
      treeMem[s2Set] <= nextTree;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Replacement always names exactly one way
  victimOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot(lookup.victimWay))
    else $error("pseudoLru: victimWay is not one-hot");

endmodule

//--- hdl/replacePkg.sv
`include "cache_macros.svh"

package replacePkg;

  ////////////////////////////////////////
  // Replacement state
  ////////////////////////////////////////

  // Binary way number
  // Used while walking or updating the tree
  typedef logic [`WAY_BITS-1:0] wayIndexT;

  // Tree pseudo-LRU bits of one set
  // Root node is the top bit, heap order below it
  // A bit of 0 points to the lower half, 1 to the upper half
  typedef logic [`NUM_WAYS-2:0] treeBitsT;

endpackage

//--- hdl/tagDirectory.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module tagDirectory (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reqValid,
  input  cacheGeomPkg::tagT      reqTag,
  input  cacheGeomPkg::setIndexT reqSet,
  input  logic                   invalidateAll,
  output logic                   respValid,
  output logic                   respHit,
  output cacheGeomPkg::wayMaskT  respWay,
  lookupIf.directory             lookup
);

  import cacheGeomPkg::*;

  // Arrays, one row per set
  tagT      tagMem [`NUM_SETS][`NUM_WAYS];
  wayMaskT  validMem [`NUM_SETS];

  // Stage two registers
  logic     s2Req;
  tagT      s2Tag;
  setIndexT s2Set;
  tagT      curTags [`NUM_WAYS];
  wayMaskT  curValid;

  // Stage two results
  wayMaskT  matchWay;
  wayMaskT  hitWay;
  logic     isHit;
  logic     missFill;

  // Stage one reads the row that stage two is filling
  logic     sameSetFill;

  ////////////////////////////////////////
  // Stage one, capture the addressed set
  ////////////////////////////////////////

  // Replacement logic reads the same row in the same cycle
  assign lookup.setIndex = reqSet;

  // Fill is dropped under invalidate, so no forwarding then
  assign sameSetFill = missFill & ~invalidateAll & (s2Set == reqSet);

  // Request strobe and cleared valid copy
  always_ff @(posedge clk) begin : stageCtrl
    if (reset) begin
      s2Req    <= 1'b0;
      curValid <= '0;
    end else begin
      s2Req <= reqValid;
      if (invalidateAll) begin
        // Same-cycle request sees an empty cache
        curValid <= '0;
      end else if (sameSetFill) begin
        curValid <= validMem[reqSet] | lookup.victimWay;
      end else begin
        curValid <= validMem[reqSet];
      end
    end
  end

  // Tag copy of the addressed set
  always_ff @(posedge clk) begin : stageData
    s2Tag <= reqTag;
    s2Set <= reqSet;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      // Victim way takes the tag being written this edge
      if (sameSetFill && lookup.victimWay[w]) begin
        curTags[w] <= s2Tag;
      end else begin
        curTags[w] <= tagMem[reqSet][w];
      end
    end
  end

  ////////////////////////////////////////
  // Stage two, compare and respond
  ////////////////////////////////////////

  // Valid tag match per way
  always_comb begin : compare
    for (int w = 0; w < `NUM_WAYS; w++) begin
      matchWay[w] = curValid[w] && (curTags[w] == s2Tag);
    end
  end

  // Only a live request can hit
  assign hitWay   = s2Req ? matchWay : '0;
  assign isHit    = |hitWay;
  assign missFill = s2Req & ~isHit;

  // Commands to the replacement logic
  assign lookup.validWay = curValid;
  assign lookup.hitWay   = hitWay;
  assign lookup.updateEn = s2Req;
  assign lookup.fill     = missFill;

  // Response, one cycle after the request strobe
  assign respValid = s2Req;
  assign respHit   = isHit;
  // Hit way, else the way being filled
  assign respWay   = isHit ? hitWay : lookup.victimWay;

  ////////////////////////////////////////
  // Array writes at the end of stage two
  ////////////////////////////////////////

  // Valid bits, cleared as a whole by invalidate
  always_ff @(posedge clk) begin : validArray
    if (reset || invalidateAll) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        validMem[s] <= '0;
      end
    end else if (missFill) begin
      validMem[s2Set] <= validMem[s2Set] | lookup.victimWay;
    end
  end

  // Tag written into the victim way on a miss
  always_ff @(posedge clk) begin : tagArray
    if (missFill && !invalidateAll) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        if (lookup.victimWay[w]) begin
          tagMem[s2Set][w] <= s2Tag;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Fills only go to missing tags, so a tag lives in one way at most
  hitWayOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(lookup.hitWay))
    else $error("tagDirectory: hitWay has more than one bit set");

  // Victim from the replacement side must name exactly one way
  respWayOneHot: assert property (@(posedge clk) disable iff (reset)
    respValid |-> $onehot(respWay))
    else $error("tagDirectory: respWay not one-hot with respValid");

endmodule

//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// Associativity
// Any power of two from 2 up works with the tree LRU
`define NUM_WAYS 4

// Set index width, 16 sets
`define SET_BITS 4

// Stored tag width
// Request address is {tag, set}, 12 bits in all
`define TAG_BITS 8

////////////////////////////////////////
// Derived values
////////////////////////////////////////

// Number of sets in every array
`define NUM_SETS (1 << `SET_BITS)

// Width of a binary way number
`define WAY_BITS ($clog2(`NUM_WAYS))

`endif

//--- tb.f
+incdir+include
hdl/cacheGeomPkg.sv
hdl/replacePkg.sv
hdl/lookupIf.sv
hdl/tagDirectory.sv
hdl/pseudoLru.sv
hdl/cacheDirectory.sv
verification/cacheDirectoryTb.sv

//--- verification/cacheDirectoryTb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheDirectoryTb;

  import cacheGeomPkg::*;

  ////////////////////////////////////////
  // Run lengths
  ////////////////////////////////////////

  localparam int RESET_CYCLES = 16;
  localparam int TABLE_LEN    = 28;
  localparam int RANDOM_COUNT = 400;
  // Bound on the whole run, with margin
  localparam int CYCLE_LIMIT  = 3 * TABLE_LEN + RANDOM_COUNT + RESET_CYCLES;

  // One stimulus row, expectations belong to this row's own request
  typedef struct packed {
    logic     reqValid;
    logic     invalidate;
    tagT      tag;
    setIndexT setIdx;
    logic     expHit;
    wayMaskT  expWay;
  } stimRowT;

  // DUT signals
  logic     clk;
  logic     reset;
  logic     reqValid;
  tagT      reqTag;
  setIndexT reqSet;
  logic     invalidateAll;
  logic     respValid;
  logic     respHit;
  wayMaskT  respWay;

  stimRowT  stimTable [TABLE_LEN];

  // Reference model, tree nodes kept in heap order from index 1
  bit       mValid [`NUM_SETS][`NUM_WAYS];
  tagT      mTag   [`NUM_SETS][`NUM_WAYS];
  bit       mNode  [`NUM_SETS][`NUM_WAYS];

  // Expectation of the request sampled on the last edge
  logic     pendValid;
  logic     pendHit;
  wayMaskT  pendWay;

  logic [31:0] lfsrState;
  int       errorCount;
  int       checkCount;
  int       cycleCount;

  cacheDirectory cacheDirectory_inst (
    .clk           (clk),
    .reset         (reset),
    .reqValid      (reqValid),
    .reqTag        (reqTag),
    .reqSet        (reqSet),
    .invalidateAll (invalidateAll),
    .respValid     (respValid),
    .respHit       (respHit),
    .respWay       (respWay)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAIL at time %0t: %s expected %0h got %0h", $time, what, expected, actual);
    end
  endtask

  // Right-shifting Galois form
  function automatic logic [31:0] galoisStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hA300_0000;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = galoisStep(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};
    end
  endtask

  task automatic clearModel();
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        mValid[s][w] = 1'b0;
        mNode[s][w]  = 1'b0;
      end
    end
  endtask

  // Invalidate first, then the lookup sees the cleared state
  task automatic modelAccess(input logic inv, input logic rv, input tagT tag,
                             input setIndexT setIdx, output logic hit, output wayMaskT way);
    int idx;
    int node;
    hit = 1'b0;
    way = '0;
    idx = -1;
    if (inv) begin
      clearModel();
    end
    if (rv) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        if (mValid[setIdx][w] && mTag[setIdx][w] == tag) begin
          idx = w;
        end
      end
      hit = (idx >= 0);
      if (!hit) begin
        // Lowest invalid way wins
        for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
          if (!mValid[setIdx][w]) begin
            idx = w;
          end
        end
        // Set full, follow the tree down from the root
        if (idx < 0) begin
          node = 1;
          while (node < `NUM_WAYS) begin
            node = 2 * node + int'(mNode[setIdx][node]);
          end
          idx = node - `NUM_WAYS;
        end
        mValid[setIdx][idx] = 1'b1;
        mTag[setIdx][idx]   = tag;
      end
      // Climb from the leaf, each parent points to the other child
      node = idx + `NUM_WAYS;
      while (node > 1) begin
        mNode[setIdx][node / 2] = (node % 2 == 0);
        node = node / 2;
      end
      way = wayMaskT'(1) << idx;
    end
  endtask

  // Drive one cycle, check the response to the previous one
  task automatic applyCycle(input logic rv, input logic inv, input tagT tag,
                            input setIndexT setIdx, input logic expHit, input wayMaskT expWay);
    @(posedge clk);
    #1;
    reqValid      = rv;
    invalidateAll = inv;
    reqTag        = tag;
    reqSet        = setIdx;
    @(negedge clk);
    checkValue(32'(respValid), 32'(pendValid), "respValid");
    if (pendValid) begin
      checkValue(32'(respHit), 32'(pendHit), "respHit");
      checkValue(32'(respWay), 32'(pendWay), "respWay");
    end
    pendValid = rv;
    pendHit   = expHit;
    pendWay   = expWay;
  endtask

  ////////////////////////////////////////
  // Directed table
  ////////////////////////////////////////

  // Columns: reqValid, invalidate, tag, set, expected hit, expected way
  task automatic loadTable();
    // Set 1 fills ways 0 to 3 in order, then a hit
    stimTable[0]  = '{1'b1, 1'b0, 8'h10, 4'd1, 1'b0, 4'b0001};
    stimTable[1]  = '{1'b0, 1'b0, 8'h00, 4'd0, 1'b0, 4'b0000};
    stimTable[2]  = '{1'b1, 1'b0, 8'h11, 4'd1, 1'b0, 4'b0010};
    stimTable[3]  = '{1'b1, 1'b0, 8'h12, 4'd1, 1'b0, 4'b0100};
    stimTable[4]  = '{1'b0, 1'b0, 8'h00, 4'd0, 1'b0, 4'b0000};
    stimTable[5]  = '{1'b1, 1'b0, 8'h13, 4'd1, 1'b0, 4'b1000};
    stimTable[6]  = '{1'b0, 1'b0, 8'h00, 4'd0, 1'b0, 4'b0000};
    stimTable[7]  = '{1'b1, 1'b0, 8'h11, 4'd1, 1'b1, 4'b0010};
    // Set 2 back to back, fill, hit way 0, then victims 2 and 1
    stimTable[8]  = '{1'b1, 1'b0, 8'h20, 4'd2, 1'b0, 4'b0001};
    stimTable[9]  = '{1'b1, 1'b0, 8'h21, 4'd2, 1'b0, 4'b0010};
    stimTable[10] = '{1'b1, 1'b0, 8'h22, 4'd2, 1'b0, 4'b0100};
    stimTable[11] = '{1'b1, 1'b0, 8'h23, 4'd2, 1'b0, 4'b1000};
    stimTable[12] = '{1'b1, 1'b0, 8'h20, 4'd2, 1'b1, 4'b0001};
    stimTable[13] = '{1'b1, 1'b0, 8'h24, 4'd2, 1'b0, 4'b0100};
    stimTable[14] = '{1'b1, 1'b0, 8'h25, 4'd2, 1'b0, 4'b0010};
    // Fill then same tag next cycle, forwarded
    stimTable[15] = '{1'b1, 1'b0, 8'h25, 4'd2, 1'b1, 4'b0010};
    stimTable[16] = '{1'b1, 1'b0, 8'h24, 4'd2, 1'b1, 4'b0100};
    stimTable[17] = '{1'b1, 1'b0, 8'h21, 4'd2, 1'b0, 4'b0001};
    stimTable[18] = '{1'b1, 1'b0, 8'h20, 4'd2, 1'b0, 4'b1000};
    stimTable[19] = '{1'b1, 1'b0, 8'h10, 4'd1, 1'b1, 4'b0001};
    // Invalidate, old tags miss and fills restart at way 0
    stimTable[20] = '{1'b0, 1'b1, 8'h00, 4'd0, 1'b0, 4'b0000};
    stimTable[21] = '{1'b1, 1'b0, 8'h10, 4'd1, 1'b0, 4'b0001};
    stimTable[22] = '{1'b1, 1'b0, 8'h20, 4'd2, 1'b0, 4'b0001};
    stimTable[23] = '{1'b1, 1'b0, 8'h11, 4'd1, 1'b0, 4'b0010};
    stimTable[24] = '{1'b1, 1'b0, 8'h23, 4'd2, 1'b0, 4'b0010};
    // Request together with invalidate sees an empty cache
    stimTable[25] = '{1'b1, 1'b1, 8'h10, 4'd1, 1'b0, 4'b0001};
    stimTable[26] = '{1'b1, 1'b0, 8'h10, 4'd1, 1'b1, 4'b0001};
    stimTable[27] = '{1'b0, 1'b0, 8'h00, 4'd0, 1'b0, 4'b0000};
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : mainSeq
    logic [31:0] bits;
    logic        rv;
    logic        inv;
    tagT         tag;
    setIndexT    setIdx;
    logic        modelHit;
    wayMaskT     modelWay;
    clk           = 1'b0;
    reset         = 1'b1;
    reqValid      = 1'b0;
    reqTag        = '0;
    reqSet        = '0;
    invalidateAll = 1'b0;
    pendValid     = 1'b0;
    pendHit       = 1'b0;
    pendWay       = '0;
    lfsrState     = 32'h5c0e_cddf;
    errorCount    = 0;
    checkCount    = 0;
    clearModel();
    loadTable();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // Model tracks the table too, so the random phase starts in step
    for (int r = 0; r < TABLE_LEN; r++) begin
      modelAccess(stimTable[r].invalidate, stimTable[r].reqValid, stimTable[r].tag,
                  stimTable[r].setIdx, modelHit, modelWay);
      applyCycle(stimTable[r].reqValid, stimTable[r].invalidate, stimTable[r].tag,
                 stimTable[r].setIdx, stimTable[r].expHit, stimTable[r].expWay);
    end

    // Two tag bits and one set bit vary, so evictions are common
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      drawBits(2, bits);
      rv = (bits[1:0] != 2'b00);
      drawBits(5, bits);
      inv = (bits[4:0] == 5'd0);
      drawBits(2, bits);
      tag = {6'h2B, bits[1:0]};
      drawBits(1, bits);
      setIdx = {3'b010, bits[0]};
      modelAccess(inv, rv, tag, setIdx, modelHit, modelWay);
      applyCycle(rv, inv, tag, setIdx, modelHit, modelWay);
    end

    // Idle cycle to see the last response
    applyCycle(1'b0, 1'b0, '0, '0, 1'b0, '0);

    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Cycle counter bounds the run
  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
